// File: run.sh
#!/bin/sh
# Build the M6502 testbench with Verilator, run it and check the log
set -e

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module m6502_tb
./obj_dir/Vm6502_tb 2>&1 | tee sim.log

if grep -q "^Test passed$" sim.log
then
   echo "Simulation PASS"
   exit 0
fi
echo "Simulation FAIL"
exit 1

// File: source/m6502_alu.sv
// M6502 ALU
// Combinational result for logic, add, compare and count operations,
// with the N V Z C flag register updated on valid requests

`timescale 1ns/1ps
`include "m6502_config.svh"

module m6502_alu (
   input  logic                     clk,
   input  logic                     reset_n,
   input  m6502_pkg::alu_req_t      req_i,
   input  logic                     valid_i,
   output logic [`M6502_DATA_W-1:0] result_o,
   output m6502_pkg::flags_t        flags_o
);

   import m6502_pkg::*;

   localparam int MSB = `M6502_DATA_W - 1;

   logic [`M6502_DATA_W:0] wide;     // Result with carry out on top
   logic                   overflow;

   always_comb
   begin
      case (req_i.op)
         ALU_OR:  wide = {1'b0, req_i.a | req_i.b};
         ALU_AND: wide = {1'b0, req_i.a & req_i.b};
         ALU_EOR: wide = {1'b0, req_i.a ^ req_i.b};
         ALU_ADC: wide = {1'b0, req_i.a} + {1'b0, req_i.b} + flags_o.c;
         ALU_CMP: wide = {1'b0, req_i.a} - {1'b0, req_i.b};   // Top bit is borrow
         ALU_INC: wide = {1'b0, req_i.a + 1'b1};
         ALU_DEC: wide = {1'b0, req_i.a - 1'b1};
         default: wide = {1'b0, req_i.a};
      endcase
   end

   assign result_o = wide[MSB:0];

   // Signed overflow when both inputs share a sign the sum does not
   assign overflow = (req_i.a[MSB] == req_i.b[MSB]) && (result_o[MSB] != req_i.a[MSB]);

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         flags_o <= '0;
      else if (valid_i)
      begin
         case (req_i.op)
            ALU_SET_C: flags_o.c <= 1'b1;
            ALU_CLR_C: flags_o.c <= 1'b0;
            default:
            begin
               flags_o.n <= result_o[MSB];
               flags_o.z <= (result_o == '0);
               if (req_i.op == ALU_ADC)
               begin
                  flags_o.c <= wide[`M6502_DATA_W];
                  flags_o.v <= overflow;
               end
               else if (req_i.op == ALU_CMP)
                  flags_o.c <= !wide[`M6502_DATA_W];    // Set when a >= b
            end
         endcase
      end
   end

endmodule

// File: source/m6502_bus_unit.sv
// M6502 operand sequencer
// Performs the memory reads and writes an addressing mode needs, one access
// per step, and returns the operand byte or the assembled 16-bit target

`timescale 1ns/1ps
`include "m6502_config.svh"

module m6502_bus_unit (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     op_start_i,
   input  m6502_pkg::decoded_t      dec_i,
   input  logic [`M6502_ADDR_W-1:0] pc_i,
   input  logic [`M6502_DATA_W-1:0] store_data_i,
   input  logic                     reset_seq_i,
   input  logic [`M6502_DATA_W-1:0] rd_data_i,
   input  logic                     ready_i,
   output m6502_pkg::bus_req_t      bus_o,
   output logic                     busy_o,
   output logic                     op_done_o,
   output logic [`M6502_DATA_W-1:0] operand_o,
   output logic [`M6502_ADDR_W-1:0] target_o
);

   import m6502_pkg::*;

   localparam logic [`M6502_ADDR_W-1:0] VEC_HI_ADDR = `M6502_RESET_VECTOR + 1'b1;

   typedef enum logic [2:0] {
      STEP_IDLE,
      STEP_VEC_LO,
      STEP_VEC_HI,
      STEP_OPERAND,
      STEP_ABS_HI,
      STEP_ZP_ACCESS
   } step_e;

   step_e                    step;
   step_e                    next_step;
   addr_mode_e               start_mode;
   addr_mode_e               mode_q;
   logic                     store_q;
   logic [`M6502_ADDR_W-1:0] pc_q;
   logic [`M6502_DATA_W-1:0] wdata_q;
   logic [`M6502_DATA_W-1:0] tmp_lo;     // Low byte of target or zero-page address

   assign start_mode = reset_seq_i ? MODE_RESET : dec_i.mode;
   assign busy_o     = (step != STEP_IDLE);

   always_comb
   begin
      bus_o = '0;
      case (step)
         STEP_VEC_LO:
         begin
            bus_o.addr = `M6502_RESET_VECTOR;
            bus_o.rd   = 1'b1;
         end
         STEP_VEC_HI:
         begin
            bus_o.addr = VEC_HI_ADDR;
            bus_o.rd   = 1'b1;
         end
         STEP_OPERAND:
         begin
            bus_o.addr = pc_q + 1'b1;
            bus_o.rd   = 1'b1;
         end
         STEP_ABS_HI:
         begin
            bus_o.addr = pc_q + 2'd2;
            bus_o.rd   = 1'b1;
         end
         STEP_ZP_ACCESS:
         begin
            bus_o.addr  = {`M6502_ZERO_PAGE_HI, tmp_lo};
            bus_o.wdata = wdata_q;
            bus_o.rd    = !store_q;
            bus_o.wr    = store_q;
         end
         default: ;
      endcase
   end

   always_comb
   begin
      case (step)
         STEP_VEC_LO:  next_step = STEP_VEC_HI;
         STEP_OPERAND: next_step = (mode_q == MODE_ABS) ? STEP_ABS_HI :
                                   (mode_q == MODE_ZP)  ? STEP_ZP_ACCESS : STEP_IDLE;
         default:      next_step = STEP_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         step      <= STEP_IDLE;
         op_done_o <= 1'b0;
      end
      else
      begin
         op_done_o <= 1'b0;
         if (op_start_i)
         begin
            case (start_mode)
               MODE_RESET:  step <= STEP_VEC_LO;
               MODE_SINGLE: op_done_o <= 1'b1;     // Nothing to fetch
               default:     step <= STEP_OPERAND;
            endcase
         end
         else if (ready_i && busy_o)
         begin
            step      <= next_step;
            op_done_o <= (next_step == STEP_IDLE);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (op_start_i)
      begin
         mode_q  <= start_mode;
         store_q <= dec_i.store;
         pc_q    <= pc_i;
         wdata_q <= store_data_i;
      end
      if (ready_i)
      begin
         case (step)
            STEP_VEC_LO:
               tmp_lo <= rd_data_i;
            STEP_OPERAND:
            begin
               tmp_lo    <= rd_data_i;
               operand_o <= rd_data_i;
            end
            STEP_VEC_HI, STEP_ABS_HI:
               target_o <= {rd_data_i, tmp_lo};
            STEP_ZP_ACCESS:
               if (!store_q)
                  operand_o <= rd_data_i;
            default: ;
         endcase
      end
   end

endmodule

// File: source/m6502_config.svh
// M6502 core configuration
// Architectural widths and the fixed addresses used by the bus sequencer

`ifndef M6502_CONFIG_SVH
`define M6502_CONFIG_SVH

`define M6502_ADDR_W 16
`define M6502_DATA_W 8

// Low byte of the reset vector, high byte follows at the next address
`define M6502_RESET_VECTOR 16'hFFFC

`define M6502_ZERO_PAGE_HI 8'h00

`endif

// File: source/m6502_control.sv
// M6502 control
// Fetch/execute FSM with the pc, instruction and A/X/Y registers.
// Retires each instruction from the sequencer result and owns the bus for fetches

`timescale 1ns/1ps
`include "m6502_config.svh"

module m6502_control (
   input  logic                     clk,
   input  logic                     reset_n,
   output logic [`M6502_DATA_W-1:0] instr_o,
   input  m6502_pkg::decoded_t      dec_i,
   output logic                     op_start_o,
   output logic [`M6502_ADDR_W-1:0] pc_o,
   output logic [`M6502_DATA_W-1:0] store_data_o,
   output logic                     reset_seq_o,
   input  logic                     op_done_i,
   input  logic [`M6502_DATA_W-1:0] operand_i,
   input  logic [`M6502_ADDR_W-1:0] target_i,
   input  logic                     unit_busy_i,
   input  m6502_pkg::bus_req_t      unit_bus_i,
   output m6502_pkg::alu_req_t      alu_req_o,
   output logic                     alu_valid_o,
   input  logic [`M6502_DATA_W-1:0] alu_result_i,
   input  m6502_pkg::flags_t        flags_i,
   input  logic [`M6502_DATA_W-1:0] rd_data_i,
   input  logic                     ready_i,
   output m6502_pkg::bus_req_t      bus_o
);

   import m6502_pkg::*;

   typedef enum logic [2:0] {
      S_WAIT,
      S_RESET,
      S_FETCH,
      S_EXECUTE,
      S_EXEC_WAIT
   } ctrl_state_e;

   ctrl_state_e              state;
   logic [`M6502_ADDR_W-1:0] pc;
   logic [`M6502_DATA_W-1:0] ir;
   logic [`M6502_DATA_W-1:0] reg_a;
   logic [`M6502_DATA_W-1:0] reg_x;
   logic [`M6502_DATA_W-1:0] reg_y;
   logic                     reset_pending;     // Vector load in flight
   logic                     retire;
   logic                     taken;
   logic [`M6502_DATA_W-1:0] src_val;
   logic [`M6502_ADDR_W-1:0] branch_off;
   bus_req_t                 fetch_req;

   assign retire = (state == S_EXEC_WAIT) && op_done_i;

   always_comb
   begin
      case (dec_i.src)
         REG_A:   src_val = reg_a;
         REG_X:   src_val = reg_x;
         REG_Y:   src_val = reg_y;
         default: src_val = operand_i;     // Loads pass the fetched byte
      endcase
   end

   always_comb
   begin
      case (dec_i.cond)
         BR_BCC: taken = !flags_i.c;
         BR_BCS: taken = flags_i.c;
         BR_BNE: taken = !flags_i.z;
         BR_BEQ: taken = flags_i.z;
      endcase
   end

   assign branch_off = {{(`M6502_ADDR_W - `M6502_DATA_W){operand_i[`M6502_DATA_W-1]}},
                        operand_i};

   assign alu_req_o   = '{op: dec_i.alu, a: src_val, b: operand_i};
   assign alu_valid_o = retire && !reset_pending &&
                        (dec_i.dst != REG_NONE || dec_i.alu inside {ALU_CMP, ALU_SET_C, ALU_CLR_C});

   always_comb
   begin
      fetch_req      = '0;
      fetch_req.addr = pc;
      fetch_req.rd   = (state == S_FETCH);
   end

   assign bus_o = unit_busy_i ? unit_bus_i : fetch_req;

   assign instr_o      = ir;
   assign pc_o         = pc;
   assign store_data_o = src_val;
   assign op_start_o   = (state == S_EXECUTE) || (state == S_RESET);
   assign reset_seq_o  = (state == S_RESET);

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state         <= S_WAIT;
         reset_pending <= 1'b0;
         pc            <= '0;
         reg_a         <= '0;
         reg_x         <= '0;
         reg_y         <= '0;
      end
      else
      begin
         case (state)
            S_WAIT:
               state <= S_RESET;
            S_RESET:
            begin
               reset_pending <= 1'b1;
               state         <= S_EXEC_WAIT;
            end
            S_FETCH:
               if (ready_i)
               begin
                  ir    <= rd_data_i;
                  state <= S_EXECUTE;
               end
            S_EXECUTE:
               state <= S_EXEC_WAIT;     // Decode settles, sequencer starts
            S_EXEC_WAIT:
               if (op_done_i)
               begin
                  state         <= S_FETCH;
                  reset_pending <= 1'b0;
                  if (reset_pending || dec_i.op == OP_JMP)
                     pc <= target_i;
                  else if (dec_i.op == OP_BRANCH && taken)
                     pc <= pc + dec_i.len + branch_off;
                  else
                     pc <= pc + dec_i.len;
                  if (!reset_pending)
                  begin
                     case (dec_i.dst)
                        REG_A:   reg_a <= alu_result_i;
                        REG_X:   reg_x <= alu_result_i;
                        REG_Y:   reg_y <= alu_result_i;
                        default: ;
                     endcase
                  end
               end
            default:
               state <= S_WAIT;
         endcase
      end
   end

endmodule

// File: source/m6502_decoder.sv
// M6502 opcode decoder
// Splits the opcode into aaabbbcc fields and builds the decoded instruction record.
// Opcodes outside the supported set come out as a one-byte NOP

`timescale 1ns/1ps
`include "m6502_config.svh"

module m6502_decoder (
   input  logic [`M6502_DATA_W-1:0] instr_i,
   output m6502_pkg::decoded_t      dec_o
);

   import m6502_pkg::*;

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   cpu_op_e    op;

   assign aaa = instr_i[7:5];
   assign bbb = instr_i[4:2];
   assign cc  = instr_i[1:0];

   always_comb
   begin
      op = OP_NOP;
      case (cc)
         2'b01:
            // Group one, zero page and immediate only, no SBC, no STA #imm
            if (aaa != 3'b111 && (bbb == 3'b001 || (bbb == 3'b010 && aaa != 3'b100)))
            begin
               case (aaa)
                  3'b000:  op = OP_ORA;
                  3'b001:  op = OP_AND;
                  3'b010:  op = OP_EOR;
                  3'b011:  op = OP_ADC;
                  3'b100:  op = OP_STA;
                  3'b101:  op = OP_LDA;
                  default: op = OP_CMP;
               endcase
            end
         2'b10:
            case ({aaa, bbb})
               6'b100_001: op = OP_STX;
               6'b100_010: op = OP_TXA;
               6'b101_000: op = OP_LDX;
               6'b101_001: op = OP_LDX;
               6'b101_010: op = OP_TAX;
               6'b110_010: op = OP_DEX;
               default:    op = OP_NOP;
            endcase
         2'b00:
            if (bbb == 3'b100 && aaa[2])
               op = OP_BRANCH;     // Only the C and Z branches
            else
            begin
               case ({aaa, bbb})
                  6'b000_110: op = OP_CLC;
                  6'b001_110: op = OP_SEC;
                  6'b100_110: op = OP_TYA;
                  6'b010_011: op = OP_JMP;
                  6'b100_001: op = OP_STY;
                  6'b100_010: op = OP_DEY;
                  6'b101_000: op = OP_LDY;
                  6'b101_001: op = OP_LDY;
                  6'b101_010: op = OP_TAY;
                  6'b110_010: op = OP_INY;
                  6'b111_010: op = OP_INX;
                  default:    op = OP_NOP;
               endcase
            end
         default:
            op = OP_NOP;
      endcase
   end

   always_comb
   begin
      dec_o.op    = op;
      dec_o.cond  = branch_cond_e'(aaa[1:0]);
      dec_o.store = (op inside {OP_STA, OP_STX, OP_STY});

      case (op)
         OP_LDA, OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY,
         OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_CMP:
            dec_o.mode = bbb[0] ? MODE_ZP : MODE_IMM;
         OP_BRANCH: dec_o.mode = MODE_IMM;
         OP_JMP:    dec_o.mode = MODE_ABS;
         default:   dec_o.mode = MODE_SINGLE;
      endcase

      case (op)
         OP_STA, OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_CMP, OP_TAX, OP_TAY:
            dec_o.src = REG_A;
         OP_STX, OP_INX, OP_DEX, OP_TXA: dec_o.src = REG_X;
         OP_STY, OP_INY, OP_DEY, OP_TYA: dec_o.src = REG_Y;
         default:                        dec_o.src = REG_NONE;
      endcase

      case (op)
         OP_LDA, OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_TXA, OP_TYA:
            dec_o.dst = REG_A;
         OP_LDX, OP_TAX, OP_INX, OP_DEX: dec_o.dst = REG_X;
         OP_LDY, OP_TAY, OP_INY, OP_DEY: dec_o.dst = REG_Y;
         default:                        dec_o.dst = REG_NONE;
      endcase

      case (op)
         OP_ORA:         dec_o.alu = ALU_OR;
         OP_AND:         dec_o.alu = ALU_AND;
         OP_EOR:         dec_o.alu = ALU_EOR;
         OP_ADC:         dec_o.alu = ALU_ADC;
         OP_CMP:         dec_o.alu = ALU_CMP;
         OP_INX, OP_INY: dec_o.alu = ALU_INC;
         OP_DEX, OP_DEY: dec_o.alu = ALU_DEC;
         OP_SEC:         dec_o.alu = ALU_SET_C;
         OP_CLC:         dec_o.alu = ALU_CLR_C;
         default:        dec_o.alu = ALU_PASS;
      endcase

      case (dec_o.mode)
         MODE_IMM, MODE_ZP: dec_o.len = 2'd2;
         MODE_ABS:          dec_o.len = 2'd3;
         default:           dec_o.len = 2'd1;
      endcase
   end

endmodule

// File: source/m6502_pkg.sv
// M6502 shared types
// Operation and mode encodings plus the records passed between the core blocks

`include "m6502_config.svh"

package m6502_pkg;

   typedef enum logic [4:0] {
      OP_NOP, OP_LDA, OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY,
      OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_CMP,
      OP_INX, OP_INY, OP_DEX, OP_DEY,
      OP_TAX, OP_TAY, OP_TXA, OP_TYA,
      OP_CLC, OP_SEC, OP_BRANCH, OP_JMP
   } cpu_op_e;

   typedef enum logic [2:0] {
      MODE_SINGLE, MODE_IMM, MODE_ZP, MODE_ABS, MODE_RESET
   } addr_mode_e;

   typedef enum logic [3:0] {
      ALU_PASS, ALU_OR, ALU_AND, ALU_EOR, ALU_ADC,
      ALU_CMP, ALU_INC, ALU_DEC, ALU_SET_C, ALU_CLR_C
   } alu_op_e;

   typedef enum logic [1:0] {
      REG_NONE, REG_A, REG_X, REG_Y
   } reg_sel_e;

   // Same order as opcode bits 6:5
   typedef enum logic [1:0] {
      BR_BCC = 2'b00,
      BR_BCS = 2'b01,
      BR_BNE = 2'b10,
      BR_BEQ = 2'b11
   } branch_cond_e;

   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } flags_t;

   typedef struct packed {
      cpu_op_e      op;
      addr_mode_e   mode;
      reg_sel_e     src;     // ALU operand a or store source
      reg_sel_e     dst;     // Write-back target
      alu_op_e      alu;
      branch_cond_e cond;
      logic         store;
      logic [1:0]   len;     // Bytes, 1 to 3
   } decoded_t;

   typedef struct packed {
      alu_op_e                  op;
      logic [`M6502_DATA_W-1:0] a;
      logic [`M6502_DATA_W-1:0] b;
   } alu_req_t;

   typedef struct packed {
      logic [`M6502_ADDR_W-1:0] addr;
      logic [`M6502_DATA_W-1:0] wdata;
      logic                     rd;
      logic                     wr;
   } bus_req_t;

endpackage

// File: source/m6502_top.sv
// M6502 core top level
// Connects control, decoder, operand sequencer and ALU to the byte-wide memory port

`timescale 1ns/1ps
`include "m6502_config.svh"

module m6502_top (
   input  logic                     clk,
   input  logic                     reset_n,
   output m6502_pkg::bus_req_t      bus_o,
   input  logic [`M6502_DATA_W-1:0] rd_data_i,
   input  logic                     ready_i
);

   import m6502_pkg::*;

   logic [`M6502_DATA_W-1:0] instr;
   decoded_t                 dec;
   logic                     op_start;
   logic [`M6502_ADDR_W-1:0] pc;
   logic [`M6502_DATA_W-1:0] store_data;
   logic                     reset_seq;
   logic                     op_done;
   logic [`M6502_DATA_W-1:0] operand;
   logic [`M6502_ADDR_W-1:0] target;
   logic                     unit_busy;
   bus_req_t                 unit_bus;
   alu_req_t                 alu_req;
   logic                     alu_valid;
   logic [`M6502_DATA_W-1:0] alu_result;
   flags_t                   flags;

   m6502_control u_control (
      .clk          (clk),
      .reset_n      (reset_n),
      .instr_o      (instr),
      .dec_i        (dec),
      .op_start_o   (op_start),
      .pc_o         (pc),
      .store_data_o (store_data),
      .reset_seq_o  (reset_seq),
      .op_done_i    (op_done),
      .operand_i    (operand),
      .target_i     (target),
      .unit_busy_i  (unit_busy),
      .unit_bus_i   (unit_bus),
      .alu_req_o    (alu_req),
      .alu_valid_o  (alu_valid),
      .alu_result_i (alu_result),
      .flags_i      (flags),
      .rd_data_i    (rd_data_i),
      .ready_i      (ready_i),
      .bus_o        (bus_o)
   );

   m6502_decoder u_decoder (
      .instr_i (instr),
      .dec_o   (dec)
   );

   m6502_bus_unit u_bus_unit (
      .clk          (clk),
      .reset_n      (reset_n),
      .op_start_i   (op_start),
      .dec_i        (dec),
      .pc_i         (pc),
      .store_data_i (store_data),
      .reset_seq_i  (reset_seq),
      .rd_data_i    (rd_data_i),
      .ready_i      (ready_i),
      .bus_o        (unit_bus),
      .busy_o       (unit_busy),
      .op_done_o    (op_done),
      .operand_o    (operand),
      .target_o     (target)
   );

   m6502_alu u_alu (
      .clk      (clk),
      .reset_n  (reset_n),
      .req_i    (alu_req),
      .valid_i  (alu_valid),
      .result_o (alu_result),
      .flags_o  (flags)
   );

endmodule

// File: tests/m6502_assert.sv
// M6502 bus protocol checks
// Bound to the core top level to watch the memory port handshake

`timescale 1ns/1ps

module m6502_assert (
   input logic                clk,
   input logic                reset_n,
   input m6502_pkg::bus_req_t bus_i,
   input logic                ready_i
);

   // One direction per access
   no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!reset_n)
                                      !(bus_i.rd && bus_i.wr))
      else $error("read and write strobes active together at %h", bus_i.addr);

   request_stable: assert property (@(posedge clk) disable iff (!reset_n)
                                    ((bus_i.rd || bus_i.wr) && !ready_i) |=> (bus_i == $past(bus_i)))
      else $error("bus request changed while ready was low");

   // Strobes drop after the first reset edge and stay low
   quiet_in_reset: assert property (@(posedge clk) !reset_n |=> !(bus_i.rd || bus_i.wr))
      else $error("bus strobe active during reset");

endmodule

bind m6502_top m6502_assert u_assert (
   .clk     (clk),
   .reset_n (reset_n),
   .bus_i   (bus_o),
   .ready_i (ready_i)
);

// File: tests/m6502_tb.sv
// M6502 core testbench
// Runs a table of small programs from a 64 KiB memory model and checks the
// reset vector reads and every completed write, with and without ready stalls

`timescale 1ns/1ps
`include "m6502_config.svh"

module m6502_tb;

   import m6502_pkg::*;

   localparam int                       NUM_BASE    = 4;
   localparam int                       NUM_TESTS   = 2 * NUM_BASE;
   localparam int                       DRIVE_DELAY = 1;
   localparam int                       CYCLES_PER_BYTE = 40;
   localparam logic [`M6502_ADDR_W-1:0] PROG_BASE   = 16'h0200;
   localparam logic [`M6502_ADDR_W-1:0] ZP_PRELOAD  = 16'h0010;

   logic                     clk;
   logic                     reset_n;
   logic                     ready;
   logic [`M6502_DATA_W-1:0] rd_data;
   bus_req_t                 bus;
   logic [`M6502_DATA_W-1:0] mem [0:(1 << `M6502_ADDR_W) - 1];

   string                    names    [NUM_TESTS];
   logic [`M6502_DATA_W-1:0] progs    [NUM_TESTS][$];
   logic [`M6502_DATA_W-1:0] zp_init  [NUM_TESTS][$];
   logic                     stall_en [NUM_TESTS];
   bus_req_t                 exp_wr   [NUM_TESTS][$];

   int                       cur_test;
   int                       wr_count;
   int                       rd_count;
   int                       loop_hits;
   logic                     running;
   logic                     stalling;
   logic                     table_built;
   logic [`M6502_ADDR_W-1:0] loop_addr;     // Final JMP-to-self
   logic [`M6502_ADDR_W-1:0] reset_reads [3];

   m6502_tb_clock u_clock (
      .clk_o (clk)
   );

   m6502_top uut (
      .clk       (clk),
      .reset_n   (reset_n),
      .bus_o     (bus),
      .rd_data_i (rd_data),
      .ready_i   (ready)
   );

   assign rd_data = mem[bus.addr];

   always @(posedge clk)
   begin
      if (reset_n && ready && bus.wr)
         mem[bus.addr] = bus.wdata;
   end

   always @(posedge clk)
   begin
      #(DRIVE_DELAY);
      ready = stalling ? (($urandom % 4) != 0) : 1'b1;
   end

   // Ready is stable from here to the completing edge
   always @(negedge clk)
   begin
      if (running && ready)
      begin
         if (bus.wr)
            record_write(bus);
         else if (bus.rd)
            record_read(bus.addr);
      end
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_write(input string name, input bus_req_t expected,
                              input bus_req_t actual);
      if (actual !== expected)
         report_error($sformatf(
            "Fail %s: expected write %h <= %h (rd %b wr %b), actual %h <= %h (rd %b wr %b)",
            name, expected.addr, expected.wdata, expected.rd, expected.wr,
            actual.addr, actual.wdata, actual.rd, actual.wr));
   endtask

   task automatic check_fetch(input string name, input logic [`M6502_ADDR_W-1:0] expected,
                              input logic [`M6502_ADDR_W-1:0] actual);
      if (actual !== expected)
         report_error($sformatf("Fail %s: expected read at %h, actual read at %h",
                                name, expected, actual));
   endtask

   task automatic record_write(input bus_req_t actual);
      if (wr_count >= exp_wr[cur_test].size())
         report_error($sformatf("Test %s wrote %h to %h after all expected writes were seen",
                                names[cur_test], actual.wdata, actual.addr));
      else
         check_write(names[cur_test], exp_wr[cur_test][wr_count], actual);
      wr_count++;
   endtask

   task automatic record_read(input logic [`M6502_ADDR_W-1:0] addr);
      if (rd_count < 3)
         check_fetch(names[cur_test], reset_reads[rd_count], addr);
      rd_count++;
      if (addr == loop_addr)
         loop_hits++;
   endtask

   function automatic logic [`M6502_DATA_W-1:0] hex_byte(input string text, input int pos);
      int value;
      value = text.substr(pos, pos + 1).atohex();
      return value[7:0];
   endfunction

   function automatic bus_req_t write_req(input logic [7:0] addr_lo, input logic [7:0] data);
      bus_req_t req;
      req       = '0;
      req.addr  = {`M6502_ZERO_PAGE_HI, addr_lo};
      req.wdata = data;
      req.wr    = 1'b1;
      return req;
   endfunction

   // Text is hex bytes separated by single spaces
   task automatic set_program(input int t, input string text);
      int i;
      for (i = 0; i < text.len(); i += 3)
         progs[t].push_back(hex_byte(text, i));
   endtask

   task automatic set_zero_page(input int t, input string text);
      int i;
      for (i = 0; i < text.len(); i += 3)
         zp_init[t].push_back(hex_byte(text, i));
   endtask

   // Entries are zero-page address and data as aa:dd
   task automatic set_writes(input int t, input string text);
      int i;
      for (i = 0; i < text.len(); i += 6)
         exp_wr[t].push_back(write_req(hex_byte(text, i), hex_byte(text, i + 3)));
   endtask

   task automatic build_table();
      int t;
      names[0] = "reset_load_store";
      set_program(0, "A9 42 85 20 A2 7F 86 21 A0 80 84 22");
      set_program(0, "A5 10 85 23 A6 11 86 24 A4 12 84 25 4C 18 02");
      set_zero_page(0, "5A C3 01");
      set_writes(0, "20:42 21:7F 22:80 23:5A 24:C3 25:01");

      names[1] = "alu_ops";
      set_program(1, "A9 F0 09 0F 85 30 25 10 85 31 49 FF 85 32 45 11 85 33");
      set_program(1, "18 69 40 85 34 69 01 85 35 38 65 12 85 36");
      set_program(1, "05 13 85 37 29 F0 85 38 4C 28 02");
      set_zero_page(1, "3C 0F 20 80");
      set_writes(1, "30:FF 31:3C 32:C3 33:CC 34:0C 35:0E 36:2F 37:AF 38:A0");

      names[2] = "moves_counts";
      set_program(2, "A9 81 AA A8 E8 88 86 40 84 41 A2 FF E8 8A 85 42");
      set_program(2, "A0 00 88 98 85 43 CA C8 86 44 84 45 EA 4C 1D 02");
      set_writes(2, "40:82 41:80 42:00 43:FF 44:FF 45:00");

      names[3] = "branches_jmp";
      set_program(3, "A9 05 C9 05 F0 02 85 50 D0 02 85 51 C5 10 B0 02 85 52");
      set_program(3, "90 02 85 53 A2 00 D0 02 86 54 F0 02 85 55");
      set_program(3, "4C 26 02 85 56 EA A9 77 85 57 C9 10 90 02 85 58");
      set_program(3, "B0 02 85 59 D0 02 85 5A F0 02 85 5B 4C 3C 02");
      set_zero_page(3, "09");
      set_writes(3, "51:05 52:05 54:00 57:77 58:77 5B:77");

      // Same programs again under random back-pressure
      for (t = 0; t < NUM_BASE; t++)
      begin
         names[t + NUM_BASE]    = {names[t], "_stall"};
         progs[t + NUM_BASE]    = progs[t];
         zp_init[t + NUM_BASE]  = zp_init[t];
         exp_wr[t + NUM_BASE]   = exp_wr[t];
         stall_en[t]            = 1'b0;
         stall_en[t + NUM_BASE] = 1'b1;
      end
   endtask

   function automatic int watchdog_cycles();
      int total;
      int t;
      total = 0;
      for (t = 0; t < NUM_TESTS; t++)
         total += progs[t].size();
      return total * CYCLES_PER_BYTE + 100 * NUM_TESTS;
   endfunction

   task automatic load_memory(input int t);
      int a;
      for (a = 0; a < (1 << `M6502_ADDR_W); a++)
         mem[a] = a[7:0] ^ a[15:8] ^ 8'h5A;
      mem[`M6502_RESET_VECTOR]     = PROG_BASE[7:0];
      mem[`M6502_RESET_VECTOR + 1] = PROG_BASE[15:8];
      for (a = 0; a < progs[t].size(); a++)
         mem[PROG_BASE + a] = progs[t][a];
      for (a = 0; a < zp_init[t].size(); a++)
         mem[ZP_PRELOAD + a] = zp_init[t][a];
   endtask

   task automatic run_test(input int t);
      cur_test  = t;
      wr_count  = 0;
      rd_count  = 0;
      loop_hits = 0;
      loop_addr = PROG_BASE + 16'(progs[t].size() - 3);
      @(posedge clk);
      #(DRIVE_DELAY);
      reset_n  = 1'b0;
      stalling = stall_en[t];
      load_memory(t);
      repeat (3) @(posedge clk);
      #(DRIVE_DELAY);
      reset_n = 1'b1;
      running = 1'b1;
      wait (loop_hits == 2);     // JMP fetched twice at its own address
      running = 1'b0;
      if (wr_count < exp_wr[t].size())
         report_error($sformatf("Test %s made only %0d of %0d expected writes",
                                names[t], wr_count, exp_wr[t].size()));
   endtask

   initial
   begin
      wait (table_built);
      repeat (watchdog_cycles()) @(posedge clk);
      report_error("Timeout: the test table did not finish within the watchdog limit");
   end

   initial
   begin
      int t;
      reset_n     = 1'b0;
      ready       = 1'b1;
      running     = 1'b0;
      stalling    = 1'b0;
      table_built = 1'b0;
      cur_test    = 0;
      loop_addr   = '0;
      void'($urandom(84));
      build_table();
      reset_reads[0] = `M6502_RESET_VECTOR;
      reset_reads[1] = `M6502_RESET_VECTOR + 1;
      reset_reads[2] = PROG_BASE;
      table_built = 1'b1;
      for (t = 0; t < NUM_TESTS; t++)
         run_test(t);
      $display("Test passed");
      $finish;
   end

endmodule

// File: tests/m6502_tb_clock.sv
// M6502 testbench clock
// Free-running 8 ns clock for the core testbench

`timescale 1ns/1ps

module m6502_tb_clock (
   output logic clk_o
);

   localparam int HALF_PERIOD = 4;

   initial
   begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

endmodule

// File: vlog.f
+incdir+source
source/m6502_pkg.sv
source/m6502_alu.sv
source/m6502_decoder.sv
source/m6502_bus_unit.sv
source/m6502_control.sv
source/m6502_top.sv
tests/m6502_tb_clock.sv
tests/m6502_assert.sv
tests/m6502_tb.sv
